/* Bender.yml */
package:
  name: matmul_accel

sources:
  - common/accel_cfg_pkg.sv
  - common/accel_ctrl_pkg.sv
  - common/operand_wr_if.sv
  - systolic/systolic_pe.sv
  - systolic/systolic_array.sv
  - systolic/operand_skew.sv
  - source/result_packer.sv
  - source/reg_block.sv
  - source/accel_sequencer.sv
  - source/matmul_accel_top.sv
  - target: test
    files:
      - verif/tb_mem_model.sv
      - verif/tb_matmul_accel.sv

/* common/accel_cfg_pkg.sv */
package accel_cfg_pkg;

  // Array geometry
  localparam int ARRAY_N   = 4;
  localparam int ROW_IDX_W = $clog2(ARRAY_N);

  // Element widths
  localparam int OPND_W = 8;
  localparam int ACC_W  = 20;
  localparam int RES_W  = 16;

  // One memory beat carries one matrix row
  localparam int RD_ROW_W = ARRAY_N * OPND_W;
  localparam int WR_ROW_W = ARRAY_N * RES_W;

  typedef logic signed [OPND_W-1:0] opnd_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic signed [RES_W-1:0]  res_t;

  // Element j sits at the low end plus j element widths
  typedef opnd_t [ARRAY_N-1:0] rd_row_t;
  typedef res_t  [ARRAY_N-1:0] wr_row_t;

  // Indexed [row][col]
  typedef acc_t [ARRAY_N-1:0][ARRAY_N-1:0] acc_mat_t;

endpackage

/* common/accel_ctrl_pkg.sv */
package accel_ctrl_pkg;

  // Host register map
  localparam int REG_ADDR_W = 6;

  localparam logic [REG_ADDR_W-1:0] ADDR_CTRL   = 6'h00;
  localparam logic [REG_ADDR_W-1:0] ADDR_STATUS = 6'h04;
  localparam logic [REG_ADDR_W-1:0] ADDR_A      = 6'h10;
  localparam logic [REG_ADDR_W-1:0] ADDR_B      = 6'h18;
  localparam logic [REG_ADDR_W-1:0] ADDR_C      = 6'h20;

  // Memory side
  localparam int MEM_ADDR_W = 32;
  localparam int BURST_LEN  = accel_cfg_pkg::ARRAY_N;

  // Skewed feed plus drain through the array
  localparam int COMPUTE_CYCLES = 3 * accel_cfg_pkg::ARRAY_N;

  typedef enum logic [3:0] {
    S_IDLE, S_RD_A_REQ, S_RD_A_DATA, S_RD_B_REQ, S_RD_B_DATA,
    S_COMPUTE, S_WR_REQ, S_WR_DATA, S_WR_RESP, S_DONE
  } seq_state_t;

endpackage

/* common/operand_wr_if.sv */
`timescale 1ns/1ps

// Row writes from the read bursts into the operand store
interface operand_wr_if;
  import accel_cfg_pkg::*;

  // One strobe per accepted read beat
  logic                 wr_o_valid;
  // Low selects A, high selects B
  logic                 is_b;
  logic [ROW_IDX_W-1:0] row;
  rd_row_t              data;

  modport seq (output wr_o_valid, is_b, row, data);

  modport store (input wr_o_valid, is_b, row, data);

endinterface

/* flist.f */
common/accel_cfg_pkg.sv
common/accel_ctrl_pkg.sv
common/operand_wr_if.sv
systolic/systolic_pe.sv
systolic/systolic_array.sv
systolic/operand_skew.sv
source/result_packer.sv
source/reg_block.sv
source/accel_sequencer.sv
source/matmul_accel_top.sv
verif/tb_mem_model.sv
verif/tb_matmul_accel.sv

/* source/accel_sequencer.sv */
`timescale 1ns/1ps

module accel_sequencer (
  input  logic                                   ap_clk,
  input  logic                                   ap_rst_n,
  input  logic                                   start_i,
  input  logic [accel_ctrl_pkg::MEM_ADDR_W-1:0]  addr_a_i,
  input  logic [accel_ctrl_pkg::MEM_ADDR_W-1:0]  addr_b_i,
  input  logic [accel_ctrl_pkg::MEM_ADDR_W-1:0]  addr_c_i,
  output logic                                   busy_o,
  output logic                                   done_o,
  operand_wr_if.seq                              opnd,
  output logic                                   compute_start_o,
  output logic [accel_cfg_pkg::ROW_IDX_W-1:0]    wr_row_o,
  input  accel_cfg_pkg::wr_row_t                 wr_data_i,
  output logic                                   mem_arvalid_o,
  input  logic                                   mem_arready_i,
  output logic [accel_ctrl_pkg::MEM_ADDR_W-1:0]  mem_araddr_o,
  input  logic                                   mem_rvalid_i,
  output logic                                   mem_rready_o,
  input  accel_cfg_pkg::rd_row_t                 mem_rdata_i,
  input  logic                                   mem_rlast_i,
  output logic                                   mem_awvalid_o,
  input  logic                                   mem_awready_i,
  output logic [accel_ctrl_pkg::MEM_ADDR_W-1:0]  mem_awaddr_o,
  output logic                                   mem_wvalid_o,
  input  logic                                   mem_wready_i,
  output accel_cfg_pkg::wr_row_t                 mem_wdata_o,
  output logic                                   mem_wlast_o,
  input  logic                                   mem_bvalid_i,
  output logic                                   mem_bready_o
);
  import accel_cfg_pkg::*;
  import accel_ctrl_pkg::*;

  seq_state_t                          state_q;
  seq_state_t                          state_d;
  logic [ROW_IDX_W-1:0]                beat_q;
  logic [$clog2(COMPUTE_CYCLES)-1:0]   cyc_q;
  logic                                rd_beat;
  logic                                wr_beat;

  assign rd_beat = mem_rvalid_i && mem_rready_o;
  assign wr_beat = mem_wvalid_o && mem_wready_i;

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:      if (start_i) state_d = S_RD_A_REQ;
      S_RD_A_REQ:  if (mem_arready_i) state_d = S_RD_A_DATA;
      S_RD_A_DATA: if (rd_beat && mem_rlast_i) state_d = S_RD_B_REQ;
      S_RD_B_REQ:  if (mem_arready_i) state_d = S_RD_B_DATA;
      S_RD_B_DATA: if (rd_beat && mem_rlast_i) state_d = S_COMPUTE;
      S_COMPUTE:   if (int'(cyc_q) == COMPUTE_CYCLES - 1) state_d = S_WR_REQ;
      S_WR_REQ:    if (mem_awready_i) state_d = S_WR_DATA;
      S_WR_DATA:   if (wr_beat && mem_wlast_o) state_d = S_WR_RESP;
      S_WR_RESP:   if (mem_bvalid_i) state_d = S_DONE;
      S_DONE:      state_d = S_IDLE;
      default:     state_d = S_IDLE;
    endcase
  end

  // Beat counter restarts with every state change
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      state_q <= S_IDLE;
      beat_q  <= '0;
      cyc_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_d != state_q) begin
        beat_q <= '0;
      end else if (rd_beat || wr_beat) begin
        beat_q <= beat_q + 1'b1;
      end
      cyc_q <= (state_q == S_COMPUTE) ? cyc_q + 1'b1 : '0;
    end
  end

  // --------------------------------------------------
  // Memory channels
  // --------------------------------------------------
  assign mem_arvalid_o = (state_q == S_RD_A_REQ) || (state_q == S_RD_B_REQ);
  assign mem_araddr_o  = (state_q == S_RD_B_REQ) ? addr_b_i : addr_a_i;
  assign mem_rready_o  = (state_q == S_RD_A_DATA) || (state_q == S_RD_B_DATA);

  assign mem_awvalid_o = (state_q == S_WR_REQ);
  assign mem_awaddr_o  = addr_c_i;
  assign mem_wvalid_o  = (state_q == S_WR_DATA);
  assign mem_wdata_o   = wr_data_i;
  assign mem_wlast_o   = mem_wvalid_o && (beat_q == ROW_IDX_W'(BURST_LEN - 1));
  assign mem_bready_o  = (state_q == S_WR_RESP);

  // Read beats go straight into the operand store
  assign opnd.wr_o_valid = rd_beat;
  assign opnd.is_b       = (state_q == S_RD_B_DATA);
  assign opnd.row        = beat_q;
  assign opnd.data       = mem_rdata_i;

  assign compute_start_o = (state_q == S_COMPUTE) && (cyc_q == '0);
  assign wr_row_o        = beat_q;

  // Busy drops together with the done pulse
  assign busy_o = (state_q != S_IDLE) && (state_q != S_DONE);
  assign done_o = (state_q == S_DONE);

  // Requests and write data hold under back-pressure
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    mem_arvalid_o && !mem_arready_i |=> mem_arvalid_o && $stable(mem_araddr_o));

  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    mem_wvalid_o && !mem_wready_i |=> mem_wvalid_o && $stable(mem_wdata_o));

endmodule

/* source/matmul_accel_top.sv */
`timescale 1ns/1ps

module matmul_accel_top (
  input  logic                                  ap_clk,
  input  logic                                  ap_rst_n,
  // Host register port
  input  logic                                  reg_wr_i,
  input  logic                                  reg_rd_i,
  input  logic [accel_ctrl_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [31:0]                           reg_wdata_i,
  output logic [31:0]                           reg_rdata_o,
  output logic                                  reg_rvalid_o,
  // Memory read
  output logic                                  mem_arvalid_o,
  input  logic                                  mem_arready_i,
  output logic [accel_ctrl_pkg::MEM_ADDR_W-1:0] mem_araddr_o,
  input  logic                                  mem_rvalid_i,
  output logic                                  mem_rready_o,
  input  logic [accel_cfg_pkg::RD_ROW_W-1:0]    mem_rdata_i,
  input  logic                                  mem_rlast_i,
  // Memory write
  output logic                                  mem_awvalid_o,
  input  logic                                  mem_awready_i,
  output logic [accel_ctrl_pkg::MEM_ADDR_W-1:0] mem_awaddr_o,
  output logic                                  mem_wvalid_o,
  input  logic                                  mem_wready_i,
  output logic [accel_cfg_pkg::WR_ROW_W-1:0]    mem_wdata_o,
  output logic                                  mem_wlast_o,
  input  logic                                  mem_bvalid_i,
  output logic                                  mem_bready_o,
  output logic                                  done_o
);
  import accel_cfg_pkg::*;
  import accel_ctrl_pkg::*;

  logic                  start;
  logic                  busy;
  logic [MEM_ADDR_W-1:0] addr_a;
  logic [MEM_ADDR_W-1:0] addr_b;
  logic [MEM_ADDR_W-1:0] addr_c;
  logic                  compute_start;
  rd_row_t               west_row;
  rd_row_t               north_row;
  logic [ARRAY_N-1:0]    west_vld;
  logic [ARRAY_N-1:0]    north_vld;
  logic                  clear;
  acc_mat_t              acc_mat;
  logic [ROW_IDX_W-1:0]  wr_row;
  wr_row_t               wr_data;

  operand_wr_if opnd_if ();

  reg_block u_regs (
    .ap_clk       (ap_clk),
    .ap_rst_n     (ap_rst_n),
    .reg_wr_i     (reg_wr_i),
    .reg_rd_i     (reg_rd_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .reg_rvalid_o (reg_rvalid_o),
    .busy_i       (busy),
    .done_i       (done_o),
    .start_o      (start),
    .addr_a_o     (addr_a),
    .addr_b_o     (addr_b),
    .addr_c_o     (addr_c)
  );

  accel_sequencer u_seq (
    .ap_clk          (ap_clk),
    .ap_rst_n        (ap_rst_n),
    .start_i         (start),
    .addr_a_i        (addr_a),
    .addr_b_i        (addr_b),
    .addr_c_i        (addr_c),
    .busy_o          (busy),
    .done_o          (done_o),
    .opnd            (opnd_if.seq),
    .compute_start_o (compute_start),
    .wr_row_o        (wr_row),
    .wr_data_i       (wr_data),
    .mem_arvalid_o   (mem_arvalid_o),
    .mem_arready_i   (mem_arready_i),
    .mem_araddr_o    (mem_araddr_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rready_o    (mem_rready_o),
    .mem_rdata_i     (mem_rdata_i),
    .mem_rlast_i     (mem_rlast_i),
    .mem_awvalid_o   (mem_awvalid_o),
    .mem_awready_i   (mem_awready_i),
    .mem_awaddr_o    (mem_awaddr_o),
    .mem_wvalid_o    (mem_wvalid_o),
    .mem_wready_i    (mem_wready_i),
    .mem_wdata_o     (mem_wdata_o),
    .mem_wlast_o     (mem_wlast_o),
    .mem_bvalid_i    (mem_bvalid_i),
    .mem_bready_o    (mem_bready_o)
  );

  operand_skew u_skew (
    .ap_clk          (ap_clk),
    .ap_rst_n        (ap_rst_n),
    .opnd            (opnd_if.store),
    .compute_start_i (compute_start),
    .west_o          (west_row),
    .north_o         (north_row),
    .west_vld_o      (west_vld),
    .north_vld_o     (north_vld),
    .clear_o         (clear)
  );

  systolic_array u_array (
    .ap_clk      (ap_clk),
    .ap_rst_n    (ap_rst_n),
    .clear_i     (clear),
    .west_i      (west_row),
    .north_i     (north_row),
    .west_vld_i  (west_vld),
    .north_vld_i (north_vld),
    .acc_o       (acc_mat)
  );

  result_packer u_pack (
    .acc_i  (acc_mat),
    .row_i  (wr_row),
    .data_o (wr_data)
  );

endmodule

/* source/reg_block.sv */
`timescale 1ns/1ps

module reg_block (
  input  logic                                  ap_clk,
  input  logic                                  ap_rst_n,
  input  logic                                  reg_wr_i,
  input  logic                                  reg_rd_i,
  input  logic [accel_ctrl_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [31:0]                           reg_wdata_i,
  output logic [31:0]                           reg_rdata_o,
  output logic                                  reg_rvalid_o,
  input  logic                                  busy_i,
  input  logic                                  done_i,
  output logic                                  start_o,
  output logic [accel_ctrl_pkg::MEM_ADDR_W-1:0] addr_a_o,
  output logic [accel_ctrl_pkg::MEM_ADDR_W-1:0] addr_b_o,
  output logic [accel_ctrl_pkg::MEM_ADDR_W-1:0] addr_c_o
);
  import accel_ctrl_pkg::*;

  logic start_req;
  logic done_flag;

  // A start already in flight counts as busy too
  assign start_req = reg_wr_i && (reg_addr_i == ADDR_CTRL) && reg_wdata_i[0] &&
                     !busy_i && !start_o;

  // --------------------------------------------------
  // Write side
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      addr_a_o <= '0;
      addr_b_o <= '0;
      addr_c_o <= '0;
    end else if (reg_wr_i) begin
      case (reg_addr_i)
        ADDR_A:  addr_a_o <= reg_wdata_i;
        ADDR_B:  addr_b_o <= reg_wdata_i;
        ADDR_C:  addr_c_o <= reg_wdata_i;
        default: ;
      endcase
    end
  end

  // Sticky done, cleared when the next run starts
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      start_o   <= 1'b0;
      done_flag <= 1'b0;
    end else begin
      start_o <= start_req;
      if (start_o) begin
        done_flag <= 1'b0;
      end else if (done_i) begin
        done_flag <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Read side, data one cycle after the strobe
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      reg_rvalid_o <= 1'b0;
    end else begin
      reg_rvalid_o <= reg_rd_i;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (reg_rd_i) begin
      case (reg_addr_i)
        ADDR_STATUS: reg_rdata_o <= {30'd0, busy_i, done_flag};
        ADDR_A:      reg_rdata_o <= addr_a_o;
        ADDR_B:      reg_rdata_o <= addr_b_o;
        ADDR_C:      reg_rdata_o <= addr_c_o;
        default:     reg_rdata_o <= '0;
      endcase
    end
  end

  // The sequencer must never see a start in the middle of a run
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n) start_o |-> !busy_i);

endmodule

/* source/result_packer.sv */
`timescale 1ns/1ps

module result_packer (
  input  accel_cfg_pkg::acc_mat_t             acc_i,
  input  logic [accel_cfg_pkg::ROW_IDX_W-1:0] row_i,
  output accel_cfg_pkg::wr_row_t              data_o
);
  import accel_cfg_pkg::*;

  // Clamp every element of the selected row into INT16
  always_comb begin
    acc_t v;
    for (int j = 0; j < ARRAY_N; j++) begin
      v = acc_i[row_i][j];
      if (v > acc_t'(2 ** (RES_W - 1) - 1)) begin
        data_o[j] = res_t'(2 ** (RES_W - 1) - 1);
      end else if (v < acc_t'(-(2 ** (RES_W - 1)))) begin
        data_o[j] = res_t'(-(2 ** (RES_W - 1)));
      end else begin
        data_o[j] = res_t'(v);
      end
    end
  end

endmodule

/* systolic/operand_skew.sv */
`timescale 1ns/1ps

module operand_skew (
  input  logic                                ap_clk,
  input  logic                                ap_rst_n,
  operand_wr_if.store                         opnd,
  input  logic                                compute_start_i,
  output accel_cfg_pkg::rd_row_t              west_o,
  output accel_cfg_pkg::rd_row_t              north_o,
  output logic [accel_cfg_pkg::ARRAY_N-1:0]   west_vld_o,
  output logic [accel_cfg_pkg::ARRAY_N-1:0]   north_vld_o,
  output logic                                clear_o
);
  import accel_cfg_pkg::*;

  rd_row_t                        a_rows [ARRAY_N];
  rd_row_t                        b_rows [ARRAY_N];
  logic                           running;
  logic [$clog2(2*ARRAY_N)-1:0]   step;

  // Operand store, one row per read beat
  always_ff @(posedge ap_clk) begin
    if (opnd.wr_o_valid) begin
      if (opnd.is_b) begin
        b_rows[opnd.row] <= opnd.data;
      end else begin
        a_rows[opnd.row] <= opnd.data;
      end
    end
  end

  // Feed runs 2N-1 steps starting the cycle after compute_start
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      running <= 1'b0;
      step    <= '0;
    end else if (compute_start_i) begin
      running <= 1'b1;
      step    <= '0;
    end else if (running) begin
      step <= step + 1'b1;
      if (int'(step) == 2 * ARRAY_N - 2) begin
        running <= 1'b0;
      end
    end
  end

  assign clear_o = running && (step == '0);

  // --------------------------------------------------
  // Diagonal skew, lane i lags lane 0 by i steps
  // --------------------------------------------------
  always_comb begin
    int                   k;
    logic                 lane_vld;
    logic [ROW_IDX_W-1:0] kk;
    for (int i = 0; i < ARRAY_N; i++) begin
      k        = int'(step) - i;
      kk       = ROW_IDX_W'(k);
      lane_vld = running && (k >= 0) && (k < ARRAY_N);
      west_vld_o[i]  = lane_vld;
      north_vld_o[i] = lane_vld;
      west_o[i]      = lane_vld ? a_rows[i][kk] : '0;
      north_o[i]     = lane_vld ? b_rows[kk][i] : '0;
    end
  end

endmodule

/* systolic/systolic_array.sv */
`timescale 1ns/1ps

module systolic_array (
  input  logic                                ap_clk,
  input  logic                                ap_rst_n,
  input  logic                                clear_i,
  input  accel_cfg_pkg::rd_row_t              west_i,
  input  accel_cfg_pkg::rd_row_t              north_i,
  input  logic [accel_cfg_pkg::ARRAY_N-1:0]   west_vld_i,
  input  logic [accel_cfg_pkg::ARRAY_N-1:0]   north_vld_i,
  output accel_cfg_pkg::acc_mat_t             acc_o
);
  import accel_cfg_pkg::*;

  // A moves east along rows, B moves south along columns
  opnd_t a_link  [ARRAY_N][ARRAY_N+1];
  opnd_t b_link  [ARRAY_N+1][ARRAY_N];
  logic  av_link [ARRAY_N][ARRAY_N+1];
  logic  bv_link [ARRAY_N+1][ARRAY_N];

  for (genvar i = 0; i < ARRAY_N; i++) begin : g_edge
    assign a_link[i][0]  = west_i[i];
    assign av_link[i][0] = west_vld_i[i];
    assign b_link[0][i]  = north_i[i];
    assign bv_link[0][i] = north_vld_i[i];
  end

  for (genvar r = 0; r < ARRAY_N; r++) begin : g_row
    for (genvar c = 0; c < ARRAY_N; c++) begin : g_col
      systolic_pe u_pe (
        .ap_clk   (ap_clk),
        .ap_rst_n (ap_rst_n),
        .clear_i  (clear_i),
        .a_i      (a_link[r][c]),
        .b_i      (b_link[r][c]),
        .a_vld_i  (av_link[r][c]),
        .b_vld_i  (bv_link[r][c]),
        .a_o      (a_link[r][c+1]),
        .b_o      (b_link[r+1][c]),
        .a_vld_o  (av_link[r][c+1]),
        .b_vld_o  (bv_link[r+1][c]),
        .acc_o    (acc_o[r][c])
      );
    end
  end

endmodule

/* systolic/systolic_pe.sv */
`timescale 1ns/1ps

module systolic_pe (
  input  logic                  ap_clk,
  input  logic                  ap_rst_n,
  input  logic                  clear_i,
  input  accel_cfg_pkg::opnd_t  a_i,
  input  accel_cfg_pkg::opnd_t  b_i,
  input  logic                  a_vld_i,
  input  logic                  b_vld_i,
  output accel_cfg_pkg::opnd_t  a_o,
  output accel_cfg_pkg::opnd_t  b_o,
  output logic                  a_vld_o,
  output logic                  b_vld_o,
  output accel_cfg_pkg::acc_t   acc_o
);
  import accel_cfg_pkg::*;

  acc_t prod;
  logic mac_en;

  assign mac_en = a_vld_i && b_vld_i;
  // Signed product widened to the accumulator
  assign prod   = a_i * b_i;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      a_vld_o <= 1'b0;
      b_vld_o <= 1'b0;
    end else begin
      a_vld_o <= a_vld_i;
      b_vld_o <= b_vld_i;
    end
  end

  // Clear may coincide with the first product
  always_ff @(posedge ap_clk) begin
    a_o <= a_i;
    b_o <= b_i;
    if (clear_i) begin
      acc_o <= mac_en ? prod : '0;
    end else if (mac_en) begin
      acc_o <= acc_o + prod;
    end
  end

  // Skewed feed keeps both operand wavefronts aligned in every cell
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n) a_vld_i == b_vld_i);

endmodule

/* verif/tb_matmul_accel.sv */
`timescale 1ns/1ps

module tb_matmul_accel;
  import accel_cfg_pkg::*;
  import accel_ctrl_pkg::*;

  localparam int MAX_STALL   = 6;
  localparam int NUM_TESTS   = 4;
  localparam int CYCLE_LIMIT =
    NUM_TESTS * (3 * MAX_STALL * BURST_LEN + COMPUTE_CYCLES + 20);

  // Matrix pattern kinds
  localparam logic [1:0] K_IDENT = 2'd0;
  localparam logic [1:0] K_RAND  = 2'd1;
  localparam logic [1:0] K_NEG   = 2'd2;
  localparam logic [1:0] K_CLAMP = 2'd3;

  typedef struct packed {
    logic [1:0]  kind;
    logic [31:0] seed;
    logic        stall;
    logic [31:0] addr_a;
    logic [31:0] addr_b;
    logic [31:0] addr_c;
  } test_t;

  localparam test_t TESTS [NUM_TESTS] = '{
    '{K_IDENT, 32'h0000_1357, 1'b0, 32'h100, 32'h110, 32'h040},
    '{K_RAND,  32'h0bad_cafe, 1'b1, 32'h120, 32'h130, 32'h080},
    '{K_NEG,   32'h0000_0001, 1'b1, 32'h140, 32'h150, 32'h0c0},
    '{K_CLAMP, 32'h0000_0002, 1'b0, 32'h160, 32'h170, 32'h100}
  };

  logic                  ap_clk;
  logic                  ap_rst_n;
  logic                  reg_wr;
  logic                  reg_rd;
  logic [REG_ADDR_W-1:0] reg_addr;
  logic [31:0]           reg_wdata;
  logic [31:0]           reg_rdata;
  logic                  reg_rvalid;
  logic                  stall_en;
  logic                  arvalid;
  logic                  arready;
  logic                  rvalid;
  logic                  rready;
  logic                  rlast;
  logic                  awvalid;
  logic                  awready;
  logic                  wvalid;
  logic                  wready;
  logic                  wlast;
  logic                  bvalid;
  logic                  bready;
  logic [MEM_ADDR_W-1:0] araddr;
  logic [MEM_ADDR_W-1:0] awaddr;
  logic [RD_ROW_W-1:0]   rdata;
  logic [WR_ROW_W-1:0]   wdata;
  logic                  done;

  int errors;
  int checks;
  int cycles;
  int mat_a [ARRAY_N][ARRAY_N];
  int mat_b [ARRAY_N][ARRAY_N];

  matmul_accel_top dut (
    .ap_clk        (ap_clk),
    .ap_rst_n      (ap_rst_n),
    .reg_wr_i      (reg_wr),
    .reg_rd_i      (reg_rd),
    .reg_addr_i    (reg_addr),
    .reg_wdata_i   (reg_wdata),
    .reg_rdata_o   (reg_rdata),
    .reg_rvalid_o  (reg_rvalid),
    .mem_arvalid_o (arvalid),
    .mem_arready_i (arready),
    .mem_araddr_o  (araddr),
    .mem_rvalid_i  (rvalid),
    .mem_rready_o  (rready),
    .mem_rdata_i   (rdata),
    .mem_rlast_i   (rlast),
    .mem_awvalid_o (awvalid),
    .mem_awready_i (awready),
    .mem_awaddr_o  (awaddr),
    .mem_wvalid_o  (wvalid),
    .mem_wready_i  (wready),
    .mem_wdata_o   (wdata),
    .mem_wlast_o   (wlast),
    .mem_bvalid_i  (bvalid),
    .mem_bready_o  (bready),
    .done_o        (done)
  );

  tb_mem_model #(.MAX_STALL(MAX_STALL), .SEED(32'h12db8ee4)) u_mem (
    .ap_clk     (ap_clk),
    .ap_rst_n   (ap_rst_n),
    .stall_en_i (stall_en),
    .arvalid_i  (arvalid),
    .arready_o  (arready),
    .araddr_i   (araddr),
    .rvalid_o   (rvalid),
    .rready_i   (rready),
    .rdata_o    (rdata),
    .rlast_o    (rlast),
    .awvalid_i  (awvalid),
    .awready_o  (awready),
    .awaddr_i   (awaddr),
    .wvalid_i   (wvalid),
    .wready_o   (wready),
    .wdata_i    (wdata),
    .wlast_i    (wlast),
    .bvalid_o   (bvalid),
    .bready_i   (bready)
  );

  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // --------------------------------------------------
  // Reference model helpers
  // --------------------------------------------------
  // One LCG step per operand
  function automatic int rand_opnd(inout int unsigned s);
    s = s * 32'd1103515245 + 32'd12345;
    return int'($signed(s[23:16]));
  endfunction

  function automatic res_t clamp_int16(input int v);
    if (v > 32767) begin
      return res_t'(32767);
    end else if (v < -32768) begin
      return res_t'(-32768);
    end
    return res_t'(v);
  endfunction

  task automatic load_matrices(input test_t t);
    int unsigned         s;
    logic [RD_ROW_W-1:0] word_a;
    logic [RD_ROW_W-1:0] word_b;
    int                  idx;
    s = t.seed;
    for (int i = 0; i < ARRAY_N; i++) begin
      for (int j = 0; j < ARRAY_N; j++) begin
        case (t.kind)
          K_IDENT: begin
            mat_a[i][j] = rand_opnd(s);
            mat_b[i][j] = (i == j) ? 1 : 0;
          end
          K_RAND: begin
            mat_a[i][j] = rand_opnd(s);
            mat_b[i][j] = rand_opnd(s);
          end
          K_NEG: begin
            mat_a[i][j] = -128;
            mat_b[i][j] = -128;
          end
          default: begin
            mat_a[i][j] = -128;
            mat_b[i][j] = 127;
          end
        endcase
      end
    end
    // Row i of each matrix is one read beat with element j at bits 8j up
    for (int i = 0; i < ARRAY_N; i++) begin
      for (int j = 0; j < ARRAY_N; j++) begin
        word_a[OPND_W*j +: OPND_W] = OPND_W'(mat_a[i][j]);
        word_b[OPND_W*j +: OPND_W] = OPND_W'(mat_b[i][j]);
      end
      u_mem.rd_mem[(t.addr_a >> 2) + i] = word_a;
      u_mem.rd_mem[(t.addr_b >> 2) + i] = word_b;
      idx = (t.addr_c >> 3) + i;
      u_mem.wr_mem[idx] = {2{32'hbad0_0000 | 32'(idx)}};
    end
  endtask

  task automatic check_result(input test_t t);
    int                  acc;
    logic [WR_ROW_W-1:0] row;
    res_t                got;
    res_t                exp;
    for (int i = 0; i < ARRAY_N; i++) begin
      row = u_mem.wr_mem[(t.addr_c >> 3) + i];
      for (int j = 0; j < ARRAY_N; j++) begin
        acc = 0;
        for (int k = 0; k < ARRAY_N; k++) begin
          acc += mat_a[i][k] * mat_b[k][j];
        end
        exp = clamp_int16(acc);
        got = row[RES_W*j +: RES_W];
        checks++;
        assert (got === exp) else begin
          $display("[FAIL] %0t ns: C[%0d][%0d] is %0d, expected %0d", $time, i, j, got, exp);
          errors++;
        end
      end
    end
  endtask

  // --------------------------------------------------
  // Register port driver tasks start on a falling edge
  // --------------------------------------------------
  task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge ap_clk);
    reg_wr = 1'b0;
  endtask

  task automatic expect_reg(input logic [REG_ADDR_W-1:0] addr, input logic [31:0] exp);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge ap_clk);
    reg_rd = 1'b0;
    checks++;
    assert (reg_rvalid === 1'b1) else begin
      $display("Register read at 0x%0h got no rvalid one cycle after the strobe", addr);
      errors++;
    end
    checks++;
    assert (reg_rdata === exp) else begin
      $display("[FAIL] %0t ns: register 0x%0h reads 0x%0h, expected 0x%0h",
               $time, addr, reg_rdata, exp);
      errors++;
    end
  endtask

  task automatic wait_done();
    while (done !== 1'b1) begin
      @(negedge ap_clk);
    end
  endtask

  // Hang guard sized from the worst-case length of all table rows
  initial begin
    cycles = 0;
    wait (ap_rst_n === 1'b1);
    while (cycles < CYCLE_LIMIT) begin
      @(posedge ap_clk);
      cycles++;
    end
    $display("Timeout: the accelerator never finished within %0d cycles", CYCLE_LIMIT);
    $display("Errors found");
    $finish;
  end

  initial begin
    int bursts0;
    int errs0;
    ap_rst_n  = 1'b0;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    stall_en  = 1'b0;
    errors    = 0;
    checks    = 0;
    repeat (16) @(posedge ap_clk);
    @(negedge ap_clk);
    ap_rst_n = 1'b1;
    @(negedge ap_clk);
    expect_reg(ADDR_STATUS, 32'h0);

    for (int t = 0; t < NUM_TESTS; t++) begin
      errs0    = errors;
      stall_en = TESTS[t].stall;
      load_matrices(TESTS[t]);
      reg_write(ADDR_A, TESTS[t].addr_a);
      reg_write(ADDR_B, TESTS[t].addr_b);
      reg_write(ADDR_C, TESTS[t].addr_c);
      expect_reg(ADDR_A, TESTS[t].addr_a);
      expect_reg(ADDR_B, TESTS[t].addr_b);
      expect_reg(ADDR_C, TESTS[t].addr_c);

      bursts0 = u_mem.ar_bursts;
      reg_write(ADDR_CTRL, 32'h1);
      @(negedge ap_clk);
      expect_reg(ADDR_STATUS, 32'h2);
      // A second start in mid-run must be dropped
      reg_write(ADDR_CTRL, 32'h1);
      wait_done();
      // The write response must already be taken when done rises
      checks++;
      assert (u_mem.b_pend == 1'b0) else begin
        $display("done_o rose before the write response was accepted");
        errors++;
      end
      @(negedge ap_clk);
      checks++;
      assert (done === 1'b0) else begin
        $display("done_o stayed high for more than one cycle");
        errors++;
      end
      expect_reg(ADDR_STATUS, 32'h1);

      checks++;
      assert (u_mem.ar_bursts - bursts0 == 2) else begin
        $display("[FAIL] %0t ns: %0d read bursts issued, expected 2",
                 $time, u_mem.ar_bursts - bursts0);
        errors++;
      end
      check_result(TESTS[t]);
      if (errors == errs0) begin
        $display("test %0d (kind %0d): passed", t, TESTS[t].kind);
      end else begin
        $display("test %0d (kind %0d): %0d failed checks", t, TESTS[t].kind, errors - errs0);
      end
    end

    checks++;
    assert (u_mem.proto_errs == 0) else begin
      $display("Write bursts put wlast on the wrong beat %0d times", u_mem.proto_errs);
      errors++;
    end

    $display("%0d tests, %0d checks, %0d failed", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* verif/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model #(
  parameter int          MAX_STALL = 6,
  parameter logic [31:0] SEED      = 32'h0
) (
  input  logic                                  ap_clk,
  input  logic                                  ap_rst_n,
  input  logic                                  stall_en_i,
  input  logic                                  arvalid_i,
  output logic                                  arready_o,
  input  logic [accel_ctrl_pkg::MEM_ADDR_W-1:0] araddr_i,
  output logic                                  rvalid_o,
  input  logic                                  rready_i,
  output logic [accel_cfg_pkg::RD_ROW_W-1:0]    rdata_o,
  output logic                                  rlast_o,
  input  logic                                  awvalid_i,
  output logic                                  awready_o,
  input  logic [accel_ctrl_pkg::MEM_ADDR_W-1:0] awaddr_i,
  input  logic                                  wvalid_i,
  output logic                                  wready_o,
  input  logic [accel_cfg_pkg::WR_ROW_W-1:0]    wdata_i,
  input  logic                                  wlast_i,
  output logic                                  bvalid_o,
  input  logic                                  bready_i
);
  import accel_cfg_pkg::*;
  import accel_ctrl_pkg::*;

  // Read and write images, each addressed in units of its own beat width
  logic [RD_ROW_W-1:0] rd_mem [256];
  logic [WR_ROW_W-1:0] wr_mem [128];

  logic        rd_pend = 1'b0;
  logic [31:0] rd_base;
  int          rd_cnt = 0;
  logic [31:0] wr_base;
  int          wr_cnt = 0;
  logic        b_pend = 1'b0;
  int          stall_cnt = 0;
  bit          seeded = 1'b0;
  // Counters the testbench looks at
  int          ar_bursts = 0;
  int          proto_errs = 0;

  initial begin
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    rlast_o   = 1'b0;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
  end

  // --------------------------------------------------
  // Transfers seen at the rising edge
  // --------------------------------------------------
  always @(posedge ap_clk) begin
    if (arvalid_i && arready_o) begin
      rd_pend   <= 1'b1;
      rd_base   <= araddr_i;
      rd_cnt    <= 0;
      ar_bursts <= ar_bursts + 1;
    end
    if (rvalid_o && rready_i) begin
      rd_cnt <= rd_cnt + 1;
      if (rlast_o) begin
        rd_pend <= 1'b0;
      end
    end
    if (awvalid_i && awready_o) begin
      wr_base <= awaddr_i;
      wr_cnt  <= 0;
    end
    if (wvalid_i && wready_o) begin
      wr_mem[(wr_base >> 3) + wr_cnt] <= wdata_i;
      wr_cnt <= wr_cnt + 1;
      if (wlast_i != (wr_cnt == BURST_LEN - 1)) begin
        proto_errs <= proto_errs + 1;
      end
      if (wlast_i) begin
        b_pend <= 1'b1;
      end
    end
    if (bvalid_o && bready_i) begin
      b_pend <= 1'b0;
    end
  end

  // --------------------------------------------------
  // Responses driven on the falling edge
  // --------------------------------------------------
  always @(negedge ap_clk) begin
    logic go;
    if (!seeded) begin
      void'($urandom(SEED));
      seeded = 1'b1;
    end
    // At most MAX_STALL idle cycles in a row
    go = 1'b1;
    if (stall_en_i && stall_cnt < MAX_STALL && $urandom_range(1, 0) == 0) begin
      go = 1'b0;
    end
    stall_cnt = go ? 0 : stall_cnt + 1;
    if (!ap_rst_n) begin
      go = 1'b0;
    end
    arready_o <= go;
    awready_o <= go;
    wready_o  <= go;
    rvalid_o  <= rd_pend && go;
    rlast_o   <= rd_pend && go && (rd_cnt == BURST_LEN - 1);
    rdata_o   <= (rd_pend && go) ? rd_mem[(rd_base >> 2) + rd_cnt] : '0;
    bvalid_o  <= b_pend && go;
  end

endmodule
